//--- lspcCore.f
+incdir+src
src/lspc_pkg.sv
src/videoSync.sv
src/cpuRegs.sv
src/rasterTimer.sv
src/vramArbiter.sv
src/vram.sv
src/fixFetch.sv
src/lspcCore.sv
test/clockGen.sv
test/lspcCore_assertions.sv
test/lspcCore_tb.sv

//--- Bender.yml
package:
  name: lspc

sources:
  - include_dirs:
      - src
    files:
      - src/lspc_pkg.sv
      - src/videoSync.sv
      - src/cpuRegs.sv
      - src/rasterTimer.sv
      - src/vramArbiter.sv
      - src/vram.sv
      - src/fixFetch.sv
      - src/lspcCore.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/clockGen.sv
      - test/lspcCore_assertions.sv
      - test/lspcCore_tb.sv

//--- test/lspcCore_tb.sv
`timescale 1ns/1ps
`include "lspc_config.svh"

module lspcCore_tb;
	import lspc_pkg::*;

	localparam int frameCycles = `LSPC_H_TOTAL * `LSPC_V_TOTAL * 4;
	// Tests need under three frames, four times that as margin
	localparam longint timeoutNs = 4 * 3 * frameCycles * 10;

	logic CLK_24M;
	logic nRESET;
	regSel_t cpuSel;
	logic cpuWrite;
	logic cpuRead;
	vramWord_t cpuWdata;
	vramWord_t cpuRdata;
	logic tileValid;
	logic tileReady;
	vramWord_t tileWord;
	logic [2:0] tileCol;
	logic irqVblank;
	logic irqTimer;
	logic lineStart;
	logic vblank;
	logic [31:0] lfsr = 32'h18b;
	vramAddr_t written [$];
	int failedTests = 0;
	int testsRun = 0;
	int errBefore;

	clockGen clocks (.CLK_24M(CLK_24M), .nRESET(nRESET));

	lspcCore dut (.*);

	bind lspcCore lspcCore_assertions chk (
		.CLK_24M, .nRESET, .cpuSel, .cpuWrite, .cpuRead, .cpuWdata, .cpuRdata,
		.cpuReqValid(regs.reqValid), .cpuReqReady(regs.reqReady), .cpuReqWrite(regs.reqWrite),
		.cpuRdValid(regs.rdValid), .busy(regs.busy),
		.pixelEn(sync.pixelEn), .vCount(sync.vCount),
		.tileValid, .tileReady, .tileWord, .tileCol,
		.lineStart, .vblank, .irqVblank, .irqTimer
	);

	// Galois LFSR, one step per bit
	function automatic logic randBit();
		lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		return lfsr[0];
	endfunction

	function automatic vramWord_t randWord();
		vramWord_t w;
		for (int i = 0; i < 16; i++)
			w[i] = randBit();
		return w;
	endfunction

	task automatic writeReg(input regSel_t sel, input vramWord_t data);
		@(negedge CLK_24M);
		cpuRead  = 1'b0;
		cpuSel   = sel;
		cpuWdata = data;
		cpuWrite = 1'b1;
		@(negedge CLK_24M);
		cpuWrite = 1'b0;
	endtask

	// Poll STATUS busy
	task automatic waitIdle();
		cpuSel  = STATUS;
		cpuRead = 1'b1;
		@(negedge CLK_24M);
		while (cpuRdata[0])
			@(negedge CLK_24M);
		cpuRead = 1'b0;
	endtask

	// One cycle read of the data register
	task automatic readData();
		cpuSel  = VRAM_DATA;
		cpuRead = 1'b1;
		@(negedge CLK_24M);
		cpuRead = 1'b0;
	endtask

	task automatic waitHigh(ref logic sig);
		@(negedge CLK_24M);
		while (!sig)
			@(negedge CLK_24M);
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (dut.chk.errCount != errBefore)
		begin
			failedTests++;
			$display("Test %0d %s: failed", testsRun, name);
		end
		else
			$display("Test %0d %s: ok", testsRun, name);
		errBefore = dut.chk.errCount;
	endtask

	initial
	begin
		#(timeoutNs);
		$display("Watchdog timeout, the run did not finish in time");
		$display("Regression failed");
		$finish;
	end

	initial
	begin
		cpuSel    = VRAM_ADDR;
		cpuWrite  = 1'b0;
		cpuRead   = 1'b0;
		cpuWdata  = '0;
		tileReady = 1'b1;
		errBefore = 0;
		waitHigh(nRESET);
		waitHigh(lineStart);
		finishTest("reset state");

		// Map rows at step 1, a scattered region at step 3
		for (int row = 0; row < 3; row++)
		begin
			writeReg(VRAM_ADDR, vramWord_t'(`LSPC_FIX_BASE + row * 32));
			waitIdle();
			writeReg(VRAM_MOD, 16'd1);
			for (int c = 0; c < `LSPC_FIX_COLS; c++)
			begin
				written.push_back(vramAddr_t'(`LSPC_FIX_BASE + row * 32 + c));
				writeReg(VRAM_DATA, randWord());
				waitIdle();
			end
		end
		writeReg(VRAM_ADDR, 16'h0100);
		waitIdle();
		writeReg(VRAM_MOD, 16'd3);
		for (int i = 0; i < 12; i++)
		begin
			written.push_back(vramAddr_t'(16'h0100 + i * 3));
			writeReg(VRAM_DATA, randWord());
			waitIdle();
		end
		foreach (written[i])
		begin
			writeReg(VRAM_ADDR, written[i]);
			waitIdle();
			readData();
		end
		finishTest("vram write and readback");

		repeat (frameCycles)
		begin
			@(negedge CLK_24M);
			tileReady = randBit();
		end
		tileReady = 1'b1;
		finishTest("tile back-pressure");

		// Drop any flag left from earlier frames
		writeReg(IRQ_ACK, 16'h0001);
		waitHigh(irqVblank);
		repeat (20) @(negedge CLK_24M);
		writeReg(IRQ_ACK, 16'h0001);
		repeat (4) @(negedge CLK_24M);
		finishTest("vblank interrupt");

		// Park the counter high before enabling the interrupt
		writeReg(MODE, 16'h0001);
		writeReg(TIMER_HI, 16'h0000);
		writeReg(TIMER_LO, 16'd1000);
		writeReg(MODE, 16'h0015);
		writeReg(TIMER_LO, 16'd20);
		waitHigh(irqTimer);
		writeReg(IRQ_ACK, 16'h0002);
		waitHigh(irqTimer);
		writeReg(MODE, 16'h0000);
		writeReg(IRQ_ACK, 16'h0002);
		repeat (4) @(negedge CLK_24M);
		finishTest("raster timer");

		$display("Tests run: %0d, failed: %0d, assertion errors: %0d",
			testsRun, failedTests, dut.chk.errCount);
		if (failedTests == 0 && dut.chk.errCount == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- test/lspcCore_assertions.sv
`timescale 1ns/1ps
`include "lspc_config.svh"

module lspcCore_assertions
	import lspc_pkg::*;
(
	input logic      CLK_24M,
	input logic      nRESET,
	input regSel_t   cpuSel,
	input logic      cpuWrite,
	input logic      cpuRead,
	input vramWord_t cpuWdata,
	input vramWord_t cpuRdata,
	input logic      cpuReqValid,
	input logic      cpuReqReady,
	input logic      cpuReqWrite,
	input logic      cpuRdValid,
	input logic      busy,
	input logic      pixelEn,
	input logic [4:0] vCount,
	input logic      tileValid,
	input logic      tileReady,
	input vramWord_t tileWord,
	input logic [2:0] tileCol,
	input logic      lineStart,
	input logic      vblank,
	input logic      irqVblank,
	input logic      irqTimer
);

	// Clocks per line and per frame
	localparam int lineLen  = `LSPC_H_TOTAL * 4;
	localparam int frameLen = lineLen * `LSPC_V_TOTAL;

	// Shadow VRAM, unwritten words stay X
	vramWord_t shadow [`LSPC_VRAM_DEPTH];
	vramAddr_t addrModel;
	vramWord_t modModel;
	vramWord_t wbModel;
	vramWord_t rbModel;
	vramWord_t modeModel;
	logic [31:0] reloadModel;
	logic [31:0] periodLen;
	logic [31:0] elapsed;
	logic [31:0] phase;
	logic loadNext;
	logic seenLine;
	logic lineDirty;
	logic [4:0] rowModel;
	logic [2:0] colExp;
	logic ackVblank;
	logic vblankPrev;
	logic newBlank;
	vramAddr_t mapAddr;
	int rasterPos;
	logic lineExp;
	logic blankExp;
	int errCount = 0;

	assign ackVblank = cpuWrite && cpuSel == IRQ_ACK && cpuWdata[0];
	assign newBlank  = lineStart && vblank && !vblankPrev;
	assign mapAddr   = `LSPC_FIX_BASE + {rowModel[4:3], 5'd0} + tileCol;
	// Line start every lineLen clocks, blank from its first line to frame end
	assign lineExp   = (rasterPos % lineLen == 0);
	assign blankExp  = (rasterPos / lineLen >= `LSPC_VBLANK_START);

	always_ff @(posedge CLK_24M)
	begin
		if (cpuWrite && !busy && cpuSel == VRAM_ADDR)
			addrModel <= cpuWdata;
		if (cpuWrite && !busy && cpuSel == VRAM_DATA)
			wbModel <= cpuWdata;
		if (cpuWrite && cpuSel == VRAM_MOD)
			modModel <= cpuWdata;
		if (cpuWrite && cpuSel == MODE)
			modeModel <= cpuWdata;
		if (cpuWrite && cpuSel == TIMER_HI)
			reloadModel[31:16] <= cpuWdata;
		if (cpuWrite && cpuSel == TIMER_LO)
			reloadModel[15:0] <= cpuWdata;
		// Accepted write lands, address steps inside its zone
		if (cpuReqValid && cpuReqReady && cpuReqWrite)
		begin
			shadow[addrModel[11:0]] <= wbModel;
			addrModel <= {addrModel[15], addrModel[14:0] + modModel[14:0]};
		end
		// Expected read buffer once the read data lands
		if (cpuRdValid)
			rbModel <= shadow[addrModel[11:0]];
		// Load takes effect one cycle after the TIMER_LO write
		loadNext <= cpuWrite && cpuSel == TIMER_LO && modeModel[0];
		phase <= pixelEn ? 32'd1 : phase + 32'd1;
		// Time since the start of the pixel period holding the load
		if (loadNext)
		begin
			elapsed <= pixelEn ? 32'd0 : phase;
			periodLen <= 32'd4 * (reloadModel + 32'd1);
		end
		else if ($rose(irqTimer))
			elapsed <= 32'd1;
		else
			elapsed <= elapsed + 32'd1;
		if (!nRESET)
			seenLine <= 1'b0;
		else if (lineStart)
			seenLine <= 1'b1;
		// Clock position within the frame
		if (!nRESET || rasterPos == frameLen - 1)
			rasterPos <= 0;
		else
			rasterPos <= rasterPos + 1;
		vblankPrev <= vblank;
		// Map words rewritten during a line make its tiles ambiguous
		if (lineStart)
			lineDirty <= 1'b0;
		else if (cpuReqValid && cpuReqReady && cpuReqWrite && addrModel[15:8] == 8'h07)
			lineDirty <= 1'b1;
		if (lineStart)
		begin
			rowModel <= vCount;
			colExp <= '0;
		end
		else if (tileValid && tileReady)
			colExp <= colExp + 3'd1;
	end

	// Quiet outputs until the first line
	resetQuiet: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		!seenLine |-> !irqVblank && !irqTimer && !tileValid)
		else
		begin
			errCount++;
			$error("Interrupt or tile output active before the first line start");
		end

	lineTiming: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		lineStart == lineExp)
		else
		begin
			errCount++;
			$error("Fail lineStart got %h expected %h", lineStart, lineExp);
		end

	blankTiming: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		vblank == blankExp)
		else
		begin
			errCount++;
			$error("Fail vblank got %h expected %h", vblank, blankExp);
		end

	// Read buffer seen through the data register
	readBack: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		cpuRead && cpuSel == VRAM_DATA |-> cpuRdata === rbModel)
		else
		begin
			errCount++;
			$error("Fail cpuRdata got %h expected %h", cpuRdata, rbModel);
		end

	// Back-pressure holds the tile
	tileHold: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		tileValid && !tileReady && !lineStart |=> $stable(tileWord) && $stable(tileCol))
		else
		begin
			errCount++;
			$error("Tile output changed while stalled");
		end

	tileData: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		tileValid && !lineStart && !lineDirty |-> tileWord === shadow[mapAddr[11:0]])
		else
		begin
			errCount++;
			$error("Fail tileWord got %h expected %h", tileWord, shadow[mapAddr[11:0]]);
		end

	tileOrder: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		tileValid && !lineStart |-> tileCol == colExp)
		else
		begin
			errCount++;
			$error("Fail tileCol got %h expected %h", tileCol, colExp);
		end

	vblankRise: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		$rose(irqVblank) |-> $past(newBlank))
		else
		begin
			errCount++;
			$error("irqVblank rose away from the blank entry");
		end

	vblankHold: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		irqVblank && !ackVblank |=> irqVblank)
		else
		begin
			errCount++;
			$error("irqVblank dropped without an acknowledge");
		end

	vblankClear: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		irqVblank && ackVblank && !newBlank |=> !irqVblank)
		else
		begin
			errCount++;
			$error("irqVblank not cleared after acknowledge");
		end

	timerPeriod: assert property (@(posedge CLK_24M) disable iff (!nRESET)
		$rose(irqTimer) |-> elapsed == periodLen)
		else
		begin
			errCount++;
			$error("Fail irqTimer period got %h expected %h", elapsed, periodLen);
		end

endmodule

//--- test/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic CLK_24M,
	output logic nRESET
);

	// 10 ns period
	initial
	begin
		CLK_24M = 1'b0;
		forever
			#5 CLK_24M = ~CLK_24M;
	end

	// Reset held for four cycles, released on a falling edge
	initial
	begin
		nRESET = 1'b0;
		repeat (4) @(posedge CLK_24M);
		@(negedge CLK_24M);
		nRESET = 1'b1;
	end

endmodule

//--- src/lspcCore.sv
`timescale 1ns/1ps
`include "lspc_config.svh"

module lspcCore
	import lspc_pkg::*;
(
	input  logic                                CLK_24M,
	input  logic                                nRESET,
	// CPU bus
	input  regSel_t                             cpuSel,
	input  logic                                cpuWrite,
	input  logic                                cpuRead,
	input  vramWord_t                           cpuWdata,
	output vramWord_t                           cpuRdata,
	// Fix tile stream
	output logic                                tileValid,
	input  logic                                tileReady,
	output vramWord_t                           tileWord,
	output logic [$clog2(`LSPC_FIX_COLS)-1:0]   tileCol,
	// Interrupts and sync
	output logic                                irqVblank,
	output logic                                irqTimer,
	output logic                                lineStart,
	output logic                                vblank
);

	localparam int vBits = $clog2(`LSPC_V_TOTAL);

	logic pixelEn;
	logic [vBits-1:0] vCount;

	// CPU side of the arbiter
	logic cpuReqValid;
	logic cpuReqReady;
	logic cpuReqWrite;
	vramAddr_t cpuReqAddr;
	vramWord_t cpuReqWdata;
	logic cpuRdValid;

	// Fetcher side of the arbiter
	logic fetchReqValid;
	logic fetchReqReady;
	vramAddr_t fetchReqAddr;
	logic fetchRdValid;
	vramWord_t rdData;

	// Memory port
	logic memWe;
	vramAddr_t memAddr;
	vramWord_t memWdata;
	vramWord_t memRdata;

	// Timer control
	logic timerLoad;
	logic [31:0] timerReload;
	logic timerMode;
	logic timerExpired;

	// Horizontal count stays inside the sync block
	videoSync sync (
		.CLK_24M(CLK_24M), .nRESET(nRESET), .pixelEn(pixelEn), .hCount(),
		.vCount(vCount), .lineStart(lineStart), .vblank(vblank)
	);

	cpuRegs regs (
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.cpuSel(cpuSel), .cpuWrite(cpuWrite), .cpuRead(cpuRead),
		.cpuWdata(cpuWdata), .cpuRdata(cpuRdata),
		.reqValid(cpuReqValid), .reqReady(cpuReqReady), .reqWrite(cpuReqWrite),
		.reqAddr(cpuReqAddr), .reqWdata(cpuReqWdata),
		.rdValid(cpuRdValid), .rdData(rdData),
		.timerLoad(timerLoad), .timerReload(timerReload), .timerMode(timerMode),
		.timerExpired(timerExpired), .lineStart(lineStart), .vblank(vblank),
		.irqVblank(irqVblank), .irqTimer(irqTimer)
	);

	rasterTimer timer (
		.CLK_24M(CLK_24M), .nRESET(nRESET), .pixelEn(pixelEn),
		.timerLoad(timerLoad), .timerReload(timerReload), .timerMode(timerMode),
		.timerExpired(timerExpired)
	);

	vramArbiter arb (
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.fetchValid(fetchReqValid), .fetchAddr(fetchReqAddr), .fetchReady(fetchReqReady),
		.cpuValid(cpuReqValid), .cpuWrite(cpuReqWrite), .cpuAddr(cpuReqAddr),
		.cpuWdata(cpuReqWdata), .cpuReady(cpuReqReady),
		.memWe(memWe), .memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata),
		.fetchRdValid(fetchRdValid), .cpuRdValid(cpuRdValid), .rdData(rdData)
	);

	vram mem (
		.CLK_24M(CLK_24M), .we(memWe), .addr(memAddr), .wdata(memWdata), .rdata(memRdata)
	);

	fixFetch fix (
		.CLK_24M(CLK_24M), .nRESET(nRESET),
		.lineStart(lineStart), .vblank(vblank), .vCount(vCount),
		.reqValid(fetchReqValid), .reqReady(fetchReqReady), .reqAddr(fetchReqAddr),
		.rdValid(fetchRdValid), .rdData(rdData),
		.tileValid(tileValid), .tileReady(tileReady), .tileWord(tileWord), .tileCol(tileCol)
	);

endmodule

//--- src/fixFetch.sv
`timescale 1ns/1ps
`include "lspc_config.svh"

module fixFetch
	import lspc_pkg::*;
#(
	parameter int vBits   = $clog2(`LSPC_V_TOTAL),
	parameter int colBits = $clog2(`LSPC_FIX_COLS)
) (
	input  logic               CLK_24M,
	input  logic               nRESET,
	input  logic               lineStart,
	input  logic               vblank,
	input  logic [vBits-1:0]   vCount,
	output logic               reqValid,
	input  logic               reqReady,
	output vramAddr_t          reqAddr,
	input  logic               rdValid,
	input  vramWord_t          rdData,
	output logic               tileValid,
	input  logic               tileReady,
	output vramWord_t          tileWord,
	output logic [colBits-1:0] tileCol
);

	typedef enum logic [1:0] {fetchIdle, fetchReq, fetchWait, fetchOut} fetchState_t;

	fetchState_t state;
	// Map row of the current line
	vramAddr_t rowAddr;
	logic lastCol;

	assign lastCol   = (tileCol == colBits'(`LSPC_FIX_COLS - 1));
	assign reqValid  = (state == fetchReq);
	assign reqAddr   = rowAddr + vramAddr_t'(tileCol);
	assign tileValid = (state == fetchOut);

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			state   <= fetchIdle;
			tileCol <= '0;
		end
		else if (lineStart)
		begin
			// Unfinished columns of the old line are dropped
			tileCol <= '0;
			state   <= vblank ? fetchIdle : fetchReq;
		end
		else
		begin
			case (state)
				fetchReq:
					if (reqReady)
						state <= fetchWait;
				fetchWait:
					if (rdValid)
						state <= fetchOut;
				fetchOut:
					// Next request only after the tile is taken
					if (tileReady)
					begin
						if (lastCol)
							state <= fetchIdle;
						else
						begin
							tileCol <= tileCol + colBits'(1);
							state   <= fetchReq;
						end
					end
				default: ;
			endcase
		end
	end

	// Row base and tile payload
	always_ff @(posedge CLK_24M)
	begin
		// Eight lines per tile row
		if (lineStart)
			rowAddr <= `LSPC_FIX_BASE + (vramAddr_t'(vCount >> 3) << 5);
		// Stale data after an abandoned line is ignored
		if (state == fetchWait && rdValid)
			tileWord <= rdData;
	end

endmodule

//--- src/vram.sv
`timescale 1ns/1ps
`include "lspc_config.svh"

module vram
	import lspc_pkg::*;
(
	input  logic      CLK_24M,
	input  logic      we,
	input  vramAddr_t addr,
	input  vramWord_t wdata,
	output vramWord_t rdata
);

	localparam int addrBits = $clog2(`LSPC_VRAM_DEPTH);

	vramWord_t mem [`LSPC_VRAM_DEPTH];

	// Upper address bits fold onto the array
	always_ff @(posedge CLK_24M)
	begin
		if (we)
			mem[addr[addrBits-1:0]] <= wdata;
		// Read before write on the same address
		rdata <= mem[addr[addrBits-1:0]];
	end

endmodule

//--- src/vramArbiter.sv
`timescale 1ns/1ps

module vramArbiter
	import lspc_pkg::*;
(
	input  logic      CLK_24M,
	input  logic      nRESET,
	// Fix fetcher, read only
	input  logic      fetchValid,
	input  vramAddr_t fetchAddr,
	output logic      fetchReady,
	// CPU port
	input  logic      cpuValid,
	input  logic      cpuWrite,
	input  vramAddr_t cpuAddr,
	input  vramWord_t cpuWdata,
	output logic      cpuReady,
	// Memory side
	output logic      memWe,
	output vramAddr_t memAddr,
	output vramWord_t memWdata,
	input  vramWord_t memRdata,
	// Read return
	output logic      fetchRdValid,
	output logic      cpuRdValid,
	output vramWord_t rdData
);

	logic cpuGrant;
	// Owner of the read in flight
	logic rdFetch;
	logic rdCpu;

	// Fetcher always wins, CPU takes free slots
	assign fetchReady = 1'b1;
	assign cpuReady   = !fetchValid;
	assign cpuGrant   = cpuValid && !fetchValid;

	assign memAddr  = fetchValid ? fetchAddr : cpuAddr;
	assign memWe    = cpuGrant && cpuWrite;
	assign memWdata = cpuWdata;

	// Data comes back one cycle after the grant
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			rdFetch <= 1'b0;
			rdCpu   <= 1'b0;
		end
		else
		begin
			rdFetch <= fetchValid;
			rdCpu   <= cpuGrant && !cpuWrite;
		end
	end

	assign fetchRdValid = rdFetch;
	assign cpuRdValid   = rdCpu;
	assign rdData       = memRdata;

endmodule

//--- src/rasterTimer.sv
`timescale 1ns/1ps

module rasterTimer (
	input  logic        CLK_24M,
	input  logic        nRESET,
	input  logic        pixelEn,
	input  logic        timerLoad,
	input  logic [31:0] timerReload,
	input  logic        timerMode,
	output logic        timerExpired
);

	// Pixel down counter
	logic [31:0] count;
	logic atZero;

	assign atZero = (count == 32'd0);

	// Expiry on the pixel that finds zero
	// A load in the same cycle takes precedence
	assign timerExpired = pixelEn && atZero && !timerLoad;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
			count <= 32'd0;
		else if (timerLoad)
			count <= timerReload;
		else if (pixelEn)
		begin
			if (!atZero)
				count <= count - 32'd1;
			else if (timerMode)
				// Auto-reload, period of reload plus one pixels
				count <= timerReload;
		end
	end

endmodule

//--- src/cpuRegs.sv
`timescale 1ns/1ps

module cpuRegs
	import lspc_pkg::*;
(
	input  logic        CLK_24M,
	input  logic        nRESET,
	input  regSel_t     cpuSel,
	input  logic        cpuWrite,
	input  logic        cpuRead,
	input  vramWord_t   cpuWdata,
	output vramWord_t   cpuRdata,
	output logic        reqValid,
	input  logic        reqReady,
	output logic        reqWrite,
	output vramAddr_t   reqAddr,
	output vramWord_t   reqWdata,
	input  logic        rdValid,
	input  vramWord_t   rdData,
	output logic        timerLoad,
	output logic [31:0] timerReload,
	output logic        timerMode,
	input  logic        timerExpired,
	input  logic        lineStart,
	input  logic        vblank,
	output logic        irqVblank,
	output logic        irqTimer
);

	vramAddr_t vramAddr;
	vramWord_t vramMod;
	vramWord_t writeBuffer;
	vramWord_t readBuffer;
	vramWord_t mode;
	vramWord_t regValue;
	logic busy;
	logic vblankQ;
	logic postAccess;
	logic ackWrite;
	logic reqTaken;

	// VRAM access only starts when idle, otherwise dropped
	assign postAccess = cpuWrite && !busy && (cpuSel == VRAM_ADDR || cpuSel == VRAM_DATA);
	assign ackWrite   = cpuWrite && (cpuSel == IRQ_ACK);
	assign reqTaken   = reqValid && reqReady;

	assign reqAddr   = vramAddr;
	assign reqWdata  = writeBuffer;
	// Auto-reload enable
	assign timerMode = mode[2];

	// One outstanding VRAM request
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			reqValid <= 1'b0;
			reqWrite <= 1'b0;
			busy     <= 1'b0;
		end
		else if (postAccess)
		begin
			reqValid <= 1'b1;
			reqWrite <= (cpuSel == VRAM_DATA);
			busy     <= 1'b1;
		end
		else if (reqTaken)
		begin
			reqValid <= 1'b0;
			// Writes end on acceptance, reads wait for data
			if (reqWrite)
				busy <= 1'b0;
		end
		else if (rdValid)
			busy <= 1'b0;
	end

	// Address, buffers and timer reload
	always_ff @(posedge CLK_24M)
	begin
		if (postAccess && cpuSel == VRAM_ADDR)
			vramAddr <= cpuWdata;
		else if (reqTaken && reqWrite)
			// Step within the zone
			vramAddr <= {vramAddr[15], vramAddr[14:0] + vramMod[14:0]};
		if (postAccess && cpuSel == VRAM_DATA)
			writeBuffer <= cpuWdata;
		if (rdValid)
			readBuffer <= rdData;
		if (cpuWrite)
		begin
			case (cpuSel)
				VRAM_MOD: vramMod <= cpuWdata;
				TIMER_HI: timerReload[31:16] <= cpuWdata;
				TIMER_LO: timerReload[15:0] <= cpuWdata;
				default: ;
			endcase
		end
	end

	// Mode, timer load strobe and interrupt flags
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			mode      <= '0;
			timerLoad <= 1'b0;
			vblankQ   <= 1'b0;
			irqVblank <= 1'b0;
			irqTimer  <= 1'b0;
		end
		else
		begin
			vblankQ <= vblank;
			if (cpuWrite && cpuSel == MODE)
				mode <= cpuWdata;
			// Load one cycle later, once both reload halves are in place
			timerLoad <= cpuWrite && (cpuSel == TIMER_LO) && mode[0];
			// Blank entry, a new event beats the acknowledge
			if (lineStart && vblank && !vblankQ)
				irqVblank <= 1'b1;
			else if (ackWrite && cpuWdata[0])
				irqVblank <= 1'b0;
			// Expiry only counts with the interrupt enabled
			if (timerExpired && mode[4])
				irqTimer <= 1'b1;
			else if (ackWrite && cpuWdata[1])
				irqTimer <= 1'b0;
		end
	end

	// Register readback
	always_comb
	begin
		case (cpuSel)
			VRAM_ADDR: regValue = vramAddr;
			VRAM_DATA: regValue = readBuffer;
			VRAM_MOD:  regValue = vramMod;
			MODE:      regValue = mode;
			TIMER_HI:  regValue = timerReload[31:16];
			TIMER_LO:  regValue = timerReload[15:0];
			STATUS:    regValue = {12'd0, irqTimer, irqVblank, vblank, busy};
			default:   regValue = '0;
		endcase
		// Bus idles at zero
		cpuRdata = cpuRead ? regValue : '0;
	end

endmodule

//--- src/videoSync.sv
`timescale 1ns/1ps
`include "lspc_config.svh"

module videoSync #(
	parameter int hBits = $clog2(`LSPC_H_TOTAL),
	parameter int vBits = $clog2(`LSPC_V_TOTAL)
) (
	input  logic             CLK_24M,
	input  logic             nRESET,
	output logic             pixelEn,
	output logic [hBits-1:0] hCount,
	output logic [vBits-1:0] vCount,
	output logic             lineStart,
	output logic             vblank
);

	// Quarter-rate phase counter
	logic [1:0] clkDiv;
	logic hLast;
	logic vLast;

	assign hLast = (hCount == hBits'(`LSPC_H_TOTAL - 1));
	assign vLast = (vCount == vBits'(`LSPC_V_TOTAL - 1));

	// One pixel every four clocks
	assign pixelEn = (clkDiv == 2'd0);

	// Counters step just before each enable
	// so every pixelEn cycle sees a fresh count
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESET)
		begin
			clkDiv <= 2'd0;
			hCount <= '0;
			vCount <= '0;
		end
		else
		begin
			clkDiv <= clkDiv + 2'd1;
			if (clkDiv == 2'd3)
			begin
				if (hLast)
				begin
					hCount <= '0;
					// Frame wrap
					vCount <= vLast ? '0 : vCount + vBits'(1);
				end
				else
					hCount <= hCount + hBits'(1);
			end
		end
	end

	// First pixel of every line, new vCount already visible
	assign lineStart = pixelEn && (hCount == '0);

	// Blank runs to the end of the frame
	assign vblank = (vCount >= vBits'(`LSPC_VBLANK_START));

endmodule

//--- src/lspc_pkg.sv
package lspc_pkg;

	// One VRAM data word
	typedef logic [15:0] vramWord_t;

	// VRAM address
	// Bit 15 selects the zone, bits 14:0 are the word offset
	typedef logic [15:0] vramAddr_t;

	// CPU register window, in bus address order
	typedef enum logic [2:0] {
		// Address load, posts a VRAM read
		VRAM_ADDR = 3'd0,
		// Write buffer on write, read buffer on read
		VRAM_DATA = 3'd1,
		// Address step after each VRAM write
		VRAM_MOD  = 3'd2,
		// Timer control bits
		MODE      = 3'd3,
		// Timer reload, upper half
		TIMER_HI  = 3'd4,
		// Timer reload, lower half
		TIMER_LO  = 3'd5,
		// Interrupt acknowledge, one bit per flag
		IRQ_ACK   = 3'd6,
		// Busy, blank and interrupt flags
		STATUS    = 3'd7
	} regSel_t;

endpackage

//--- src/lspc_config.svh
`ifndef LSPC_CONFIG_SVH
`define LSPC_CONFIG_SVH

// Raster size, pixels per line and lines per frame
`define LSPC_H_TOTAL 64
`define LSPC_V_TOTAL 32

// First line of vertical blank
`define LSPC_VBLANK_START 24

// Fix tiles fetched on each active line
`define LSPC_FIX_COLS 8

// Fix map start in VRAM, 32 words per tile row
`define LSPC_FIX_BASE 16'h0700

// VRAM size in words
`define LSPC_VRAM_DEPTH 4096

`endif
